// File: source/wire_pkg.sv
// ********************
// wire game package
// shared codes, sizes and the layout and button event types
// ********************
package wire_pkg;

    // game states
    localparam logic [2:0] state_menu = 3'd0;
    localparam logic [2:0] state_play = 3'd1;
    localparam logic [2:0] state_lost = 3'd2;
    localparam logic [2:0] state_won  = 3'd3;

    // puzzle modes, only wire is played here
    localparam logic [2:0] mode_mod  = 3'd0;
    localparam logic [2:0] mode_maze = 3'd1;
    localparam logic [2:0] mode_wire = 3'd2;

    // one-hot button codes
    localparam logic [5:0] btn_select = 6'b000001;
    localparam logic [5:0] btn_up     = 6'b000010;
    localparam logic [5:0] btn_right  = 6'b000100;
    localparam logic [5:0] btn_down   = 6'b001000;
    localparam logic [5:0] btn_left   = 6'b010000;
    localparam logic [5:0] btn_back   = 6'b100000;
    localparam logic [5:0] btn_none   = 6'b000000;

    // wire colours
    localparam logic [2:0] col_red    = 3'd0;
    localparam logic [2:0] col_white  = 3'd1;
    localparam logic [2:0] col_yellow = 3'd2;
    localparam logic [2:0] col_blue   = 3'd3;
    localparam logic [2:0] col_black  = 3'd4;
    localparam logic [2:0] col_none   = 3'd5;  // unused position

    localparam int max_wires    = 6;
    localparam int strike_limit = 3;

    typedef struct packed {
        logic [2:0]      wire_num;  // 3 to 6
        logic [5:0][2:0] colors;    // position 0 in the low bits
    } wire_layout_t;

    typedef struct packed {
        logic       strobe;  // one-cycle event
        logic [5:0] code;    // one-hot button
    } button_evt_t;

endpackage

// File: source/button_sync.sv
// ********************
// button synchroniser
// two-stage sync and rising-edge detect, one event per press
// ********************
`timescale 1ns/1ps

module button_sync (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic [5:0]           buttons,  // raw, asynchronous
    output wire_pkg::button_evt_t btn_evt
);
    import wire_pkg::*;

    logic [5:0] sync1;   // first flop, may go metastable
    logic [5:0] sync2;   // stable copy
    logic [5:0] prev;    // sync2 one cycle ago
    logic [5:0] rise;    // newly pressed bits
    logic [5:0] lowest;  // lowest risen bit only

    assign rise   = sync2 & ~prev;
    assign lowest = rise & (~rise + 6'd1);  // isolate lowest set bit

    always_ff @(posedge clk) begin
        if (!nrst) begin
            sync1          <= 6'd0;
            sync2          <= 6'd0;
            prev           <= 6'd0;
            btn_evt.strobe <= 1'b0;
            btn_evt.code   <= btn_none;
        end else begin
            sync1          <= buttons;
            sync2          <= sync1;
            prev           <= sync2;
            btn_evt.strobe <= |rise;   // simultaneous presses give one event
            btn_evt.code   <= lowest;  // btn_none when nothing rose
        end
    end

endmodule

// File: source/wire_layout_gen.sv
// ********************
// wire layout generator
// free-running lfsr sampled into a new layout at round start
// ********************
`timescale 1ns/1ps

module wire_layout_gen (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  activate_rand,  // round start pulse
    output wire_pkg::wire_layout_t layout
);
    import wire_pkg::*;

    logic [23:0]  lfsr;       // x^24 + x^23 + x^22 + x^17 + 1
    logic         feedback;
    wire_layout_t nxt_layout;  // layout built from current lfsr
    logic [2:0]   raw_col;

    assign feedback = lfsr[23] ^ lfsr[22] ^ lfsr[21] ^ lfsr[16];

    always_comb begin
        nxt_layout.wire_num = 3'd3 + {1'b0, lfsr[1:0]};  // 3 to 6
        nxt_layout.colors   = '0;
        raw_col             = 3'd0;
        for (int i = 0; i < max_wires; i++) begin
            raw_col = lfsr[2 + 3 * i +: 3];
            if (3'(i) >= nxt_layout.wire_num) begin
                nxt_layout.colors[i] = col_none;              // no wire here
            end else if (raw_col > col_black) begin
                nxt_layout.colors[i] = raw_col - 3'd5;        // fold 5..7 onto 0..2
            end else begin
                nxt_layout.colors[i] = raw_col;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            lfsr            <= 24'h5ac3e1;  // any nonzero seed
            layout.wire_num <= 3'd3;
            layout.colors   <= {col_none, col_none, col_none, col_blue, col_white, col_red};
        end else begin
            lfsr <= {lfsr[22:0], feedback};  // runs every cycle
            if (activate_rand) begin
                layout <= nxt_layout;
            end
        end
    end

endmodule

// File: source/wire_rule_solver.sv
// ********************
// wire rule solver
// colour rule table, names the position of the wire to cut
// ********************
`timescale 1ns/1ps

module wire_rule_solver (
    input  wire_pkg::wire_layout_t layout,
    output logic [2:0]            right_wire
);
    import wire_pkg::*;

    logic [2:0] n_red;      // colour counts over used positions
    logic [2:0] n_white;
    logic [2:0] n_yellow;
    logic [2:0] n_blue;
    logic [2:0] n_black;
    logic [2:0] last_red;   // highest position holding red
    logic [2:0] last_blue;  // highest position holding blue
    logic [2:0] last_pos;   // index of the last wire
    logic [2:0] last_col;   // colour of the last wire

    assign last_pos = layout.wire_num - 3'd1;
    assign last_col = layout.colors[last_pos];

    always_comb begin
        n_red     = 3'd0;
        n_white   = 3'd0;
        n_yellow  = 3'd0;
        n_blue    = 3'd0;
        n_black   = 3'd0;
        last_red  = 3'd0;
        last_blue = 3'd0;
        for (int i = 0; i < max_wires; i++) begin
            if (3'(i) < layout.wire_num) begin
                case (layout.colors[i])
                    col_red: begin
                        n_red    = n_red + 3'd1;
                        last_red = 3'(i);  // later positions overwrite
                    end
                    col_white:  n_white  = n_white + 3'd1;
                    col_yellow: n_yellow = n_yellow + 3'd1;
                    col_blue: begin
                        n_blue    = n_blue + 3'd1;
                        last_blue = 3'(i);
                    end
                    col_black:  n_black  = n_black + 3'd1;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        right_wire = 3'd0;
        case (layout.wire_num)
            3'd3: begin
                if (n_red == 3'd0)                          right_wire = 3'd1;
                else if (last_col == col_white)             right_wire = last_pos;
                else if (n_blue > 3'd1)                     right_wire = last_blue;
                else                                        right_wire = last_pos;
            end
            3'd4: begin
                if (n_red > 3'd1)                           right_wire = last_red;
                else if (n_red == 3'd0 && last_col == col_yellow) right_wire = 3'd0;
                else if (n_blue == 3'd1)                    right_wire = 3'd0;
                else if (n_yellow > 3'd1)                   right_wire = last_pos;
                else                                        right_wire = 3'd1;
            end
            3'd5: begin
                if (last_col == col_black)                  right_wire = 3'd3;
                else if (n_red == 3'd1 && n_yellow > 3'd1)  right_wire = 3'd0;
                else if (n_black == 3'd0)                   right_wire = 3'd1;
                else                                        right_wire = 3'd0;
            end
            3'd6: begin
                if (n_yellow == 3'd0)                       right_wire = 3'd2;
                else if (n_yellow == 3'd1 && n_white > 3'd1) right_wire = 3'd3;
                else if (n_red == 3'd0)                     right_wire = last_pos;
                else                                        right_wire = 3'd3;
            end
            default: right_wire = 3'd0;  // wire_num out of range
        endcase
    end

endmodule

// File: source/wire_cut_detector.sv
// ********************
// wire cut detector
// keeps the cut flags and judges each new cut
// ********************
`timescale 1ns/1ps

module wire_cut_detector (
    input  logic                              clk,
    input  logic                              nrst,
    input  logic                              activate_rand,  // new round, clear flags
    input  logic [2:0]                        game_state,
    input  logic [2:0]                        mode,
    input  wire_pkg::button_evt_t             btn_evt,
    input  logic [2:0]                        wire_pos,       // cursor
    input  logic [2:0]                        right_wire,     // from solver
    output logic [wire_pkg::max_wires-1:0]    wire_status,    // 1 means cut
    output logic                              wire_clear,     // right wire cut
    output logic                              wire_error      // wrong wire cut
);
    import wire_pkg::*;

    logic cut_req;  // select pressed while playing wires
    logic new_cut;  // target wire still uncut

    assign cut_req = (game_state == state_play) && (mode == mode_wire) &&
                     btn_evt.strobe && (btn_evt.code == btn_select);
    assign new_cut = cut_req && !wire_status[wire_pos];  // re-cut is ignored

    assign wire_clear = new_cut && (wire_pos == right_wire);
    assign wire_error = new_cut && (wire_pos != right_wire);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            wire_status <= '0;
        end else if (activate_rand) begin
            wire_status <= '0;  // fresh layout
        end else if (new_cut) begin
            wire_status[wire_pos] <= 1'b1;
        end
    end

endmodule

// File: source/wire_cursor.sv
// ********************
// wire cursor
// selected wire position, wraps within the wire count
// ********************
`timescale 1ns/1ps

module wire_cursor (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  activate_rand,
    input  logic [2:0]            game_state,
    input  logic [2:0]            mode,
    input  wire_pkg::button_evt_t btn_evt,
    input  wire_pkg::wire_layout_t layout,
    output logic [2:0]            wire_pos
);
    import wire_pkg::*;

    logic [2:0] last_pos;  // highest valid position
    logic       move_ok;   // cursor keys are live

    assign last_pos = layout.wire_num - 3'd1;
    assign move_ok  = (game_state == state_play) && (mode == mode_wire) && btn_evt.strobe;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            wire_pos <= 3'd0;
        end else if (activate_rand) begin
            wire_pos <= 3'd0;  // new round starts at the first wire
        end else if (move_ok) begin
            case (btn_evt.code)
                btn_right: wire_pos <= (wire_pos == last_pos) ? 3'd0 : wire_pos + 3'd1;
                btn_left:  wire_pos <= (wire_pos == 3'd0) ? last_pos : wire_pos - 3'd1;
                default: ;
            endcase
        end
    end

endmodule

// File: source/game_fsm.sv
// ********************
// game state machine
// menu, play, won and lost with the strike count
// ********************
`timescale 1ns/1ps

module game_fsm (
    input  logic                  clk,
    input  logic                  nrst,
    input  wire_pkg::button_evt_t btn_evt,
    input  logic                  wire_clear,
    input  logic                  wire_error,
    output logic [2:0]            game_state,
    output logic [1:0]            strikes,
    output logic                  activate_rand  // pulse on menu to play
);
    import wire_pkg::*;

    logic press_select;
    logic press_back;

    assign press_select = btn_evt.strobe && (btn_evt.code == btn_select);
    assign press_back   = btn_evt.strobe && (btn_evt.code == btn_back);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            game_state    <= state_menu;
            strikes       <= 2'd0;
            activate_rand <= 1'b0;
        end else begin
            activate_rand <= 1'b0;  // default low, single-cycle pulse
            case (game_state)
                state_menu: if (press_select) begin
                    game_state    <= state_play;
                    strikes       <= 2'd0;
                    activate_rand <= 1'b1;  // ask for a fresh layout
                end
                state_play: begin
                    if (wire_clear) begin
                        game_state <= state_won;
                    end else if (wire_error) begin
                        strikes <= strikes + 2'd1;
                        if (strikes == 2'(strike_limit - 1))
                            game_state <= state_lost;  // last strike
                    end
                end
                state_won, state_lost: if (press_back) game_state <= state_menu;
                default: game_state <= state_menu;  // unused codes recover
            endcase
        end
    end

endmodule

// File: source/wire_game_top.sv
// ********************
// wire game top
// buttons in, wire puzzle state out
// ********************
`timescale 1ns/1ps

module wire_game_top (
    input  logic                               clk,
    input  logic                               nrst,
    input  logic [5:0]                         buttons,  // raw buttons
    input  logic [2:0]                         mode,     // puzzle select
    output wire_pkg::wire_layout_t             layout,
    output logic [2:0]                         wire_pos,
    output logic [wire_pkg::max_wires-1:0]     wire_status,
    output logic [2:0]                         game_state,
    output logic [1:0]                         strikes,
    output logic                               wire_clear,
    output logic                               wire_error
);
    import wire_pkg::*;

    button_evt_t btn_evt;        // synced button event
    logic        activate_rand;  // round start
    logic [2:0]  right_wire;     // solver answer

    button_sync u_button_sync (
        .clk(clk), .nrst(nrst), .buttons(buttons), .btn_evt(btn_evt)
    );

    game_fsm u_game_fsm (
        .clk(clk), .nrst(nrst), .btn_evt(btn_evt),
        .wire_clear(wire_clear), .wire_error(wire_error),
        .game_state(game_state), .strikes(strikes), .activate_rand(activate_rand)
    );

    wire_layout_gen u_wire_layout_gen (
        .clk(clk), .nrst(nrst), .activate_rand(activate_rand), .layout(layout)
    );

    wire_rule_solver u_wire_rule_solver (.layout(layout), .right_wire(right_wire));

    wire_cursor u_wire_cursor (
        .clk(clk), .nrst(nrst), .activate_rand(activate_rand), .game_state(game_state),
        .mode(mode), .btn_evt(btn_evt), .layout(layout), .wire_pos(wire_pos)
    );

    wire_cut_detector u_wire_cut_detector (
        .clk(clk), .nrst(nrst), .activate_rand(activate_rand), .game_state(game_state),
        .mode(mode), .btn_evt(btn_evt), .wire_pos(wire_pos), .right_wire(right_wire),
        .wire_status(wire_status), .wire_clear(wire_clear), .wire_error(wire_error)
    );

endmodule

// File: tests/wire_game_tb.sv
// ********************
// wire game testbench
// plays table-driven rounds against a reference rule model
// ********************
`timescale 1ns/1ps

module wire_game_tb;
    import wire_pkg::*;

    typedef struct packed {
        logic [2:0] mode;       // mode used for the gating check
        logic [1:0] n_wrong;    // wrong cuts before the right one
        logic [2:0] exp_state;  // round outcome
    } round_row_t;

    logic                 clk;
    logic                 nrst;
    logic [5:0]           buttons;
    logic [2:0]           mode;
    wire_layout_t         layout;
    logic [2:0]           wire_pos;
    logic [max_wires-1:0] wire_status;
    logic [2:0]           game_state;
    logic [1:0]           strikes;
    logic                 wire_clear;
    logic                 wire_error;

    int         errors = 0;
    int         seed   = 32'hdb70fb36;
    round_row_t rounds [0:7];
    int         clear_cnt = 0;  // wire_clear pulses seen
    int         error_cnt = 0;  // wire_error pulses seen
    logic [max_wires-1:0] cut_mask;  // wires cut so far this round

    wire_game_top u_dut (
        .clk(clk), .nrst(nrst), .buttons(buttons), .mode(mode),
        .layout(layout), .wire_pos(wire_pos), .wire_status(wire_status),
        .game_state(game_state), .strikes(strikes),
        .wire_clear(wire_clear), .wire_error(wire_error)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        #2000000;  // hang guard
        $display("simulation ran too long and was stopped");
        $display("TESTS FAILED");
        $finish;
    end

    // judge pulses follow the strobe, steady by the falling edge
    always @(negedge clk) begin
        if (wire_clear) clear_cnt++;
        if (wire_error) error_cnt++;
    end

    task automatic check_val(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_pulses(input int clear0, input int error0,
                                input int exp_clear, input int exp_error);
        check_val("wire_clear pulses", clear_cnt - clear0, exp_clear);
        check_val("wire_error pulses", error_cnt - error0, exp_error);
    endtask

    task automatic press(input logic [5:0] code);
        @(negedge clk);
        buttons = code;
        repeat (4) @(negedge clk);
        buttons = 6'd0;
        repeat (4) @(negedge clk);  // release time, event has settled
    endtask

    task automatic wait_state(input logic [2:0] exp);
        int n;
        n = 0;
        while (game_state != exp && n < 40) begin
            @(negedge clk);
            n++;
        end
        assert (game_state == exp) else begin
            $display("timed out waiting for game_state %0d, still %0d", exp, game_state);
            errors++;
        end
    endtask

    task automatic wait_pos(input int exp);
        int n;
        n = 0;
        while (int'(wire_pos) != exp && n < 40) begin
            @(negedge clk);
            n++;
        end
        assert (int'(wire_pos) == exp) else begin
            $display("timed out waiting for wire_pos %0d, still %0d", exp, wire_pos);
            errors++;
        end
    endtask

    task automatic wait_status(input logic [max_wires-1:0] exp);
        int n;
        n = 0;
        while (wire_status != exp && n < 40) begin
            @(negedge clk);
            n++;
        end
        assert (wire_status == exp) else begin
            $display("timed out waiting for wire_status %h, still %h", exp, wire_status);
            errors++;
        end
    endtask

    // classic colour rules, written from the rule table
    function automatic int model_right(input wire_layout_t l);
        int n;
        int red;
        int white;
        int yellow;
        int blue;
        int black;
        int last_red;
        int last_blue;
        int last_col;
        n = int'(l.wire_num);
        red = 0;
        white = 0;
        yellow = 0;
        blue = 0;
        black = 0;
        last_red = 0;
        last_blue = 0;
        for (int i = 0; i < n; i++) begin
            if (l.colors[i] == col_red) begin
                red++;
                last_red = i;
            end
            if (l.colors[i] == col_white)  white++;
            if (l.colors[i] == col_yellow) yellow++;
            if (l.colors[i] == col_blue) begin
                blue++;
                last_blue = i;
            end
            if (l.colors[i] == col_black)  black++;
        end
        last_col = int'(l.colors[n-1]);
        case (n)
            3: begin
                if (red == 0)                       return 1;
                if (last_col == int'(col_white))    return n - 1;
                if (blue > 1)                       return last_blue;
                return n - 1;
            end
            4: begin
                if (red > 1)                                     return last_red;
                if (red == 0 && last_col == int'(col_yellow))    return 0;
                if (blue == 1)                                   return 0;
                if (yellow > 1)                                  return n - 1;
                return 1;
            end
            5: begin
                if (last_col == int'(col_black))    return 3;
                if (red == 1 && yellow > 1)         return 0;
                if (black == 0)                     return 1;
                return 0;
            end
            default: begin
                if (yellow == 0)                    return 2;
                if (yellow == 1 && white > 1)       return 3;
                if (red == 0)                       return n - 1;
                return 3;
            end
        endcase
    endfunction

    task automatic check_layout();
        int n;
        n = int'(layout.wire_num);
        assert (n >= 3 && n <= 6) else begin
            $display("[ERROR] layout.wire_num got %h expected 3 to 6", n);
            errors++;
        end
        for (int i = 0; i < max_wires; i++) begin
            if (i < n) begin
                assert (layout.colors[i] <= col_black) else begin
                    $display("[ERROR] layout.colors[%0d] got %h expected 0 to 4", i,
                             layout.colors[i]);
                    errors++;
                end
            end else begin
                check_val("layout.colors", int'(layout.colors[i]), int'(col_none));
            end
        end
    endtask

    // random uncut wrong wire, found = 0 when none is left
    task automatic pick_wrong(input int right, output int pos, output bit found);
        int cand[$];
        for (int i = 0; i < int'(layout.wire_num); i++)
            if (i != right && !cut_mask[i]) cand.push_back(i);
        found = (cand.size() > 0);
        pos   = 0;
        if (found) begin
            pos = cand[$unsigned($random(seed)) % cand.size()];
        end
    endtask

    task automatic steer_to(input int target);
        int n;
        int steps;
        n = int'(layout.wire_num);
        steps = (target + n - int'(wire_pos)) % n;  // wrap distance to the right
        repeat (steps) begin
            press(btn_right);
            wait_pos((target + n - steps + 1) % n);
            steps--;
        end
    endtask

    task automatic cut_at(input int pos, input int exp_strikes, input bit right_cut);
        int clear0;
        int error0;
        cut_mask[pos] = 1'b1;
        steer_to(pos);
        clear0 = clear_cnt;
        error0 = error_cnt;
        press(btn_select);
        wait_status(cut_mask);
        check_val("strikes", int'(strikes), exp_strikes);
        check_pulses(clear0, error0, right_cut ? 1 : 0, right_cut ? 0 : 1);
    endtask

    initial begin
        int right;
        int wrong;
        int wrong_done;
        int n;
        int clear0;
        int error0;
        bit found;
        logic [2:0] exp_state;

        rounds[0] = '{mode_wire, 2'd0, state_won};
        rounds[1] = '{mode_maze, 2'd1, state_won};
        rounds[2] = '{mode_wire, 2'd3, state_lost};
        rounds[3] = '{mode_wire, 2'd2, state_won};
        rounds[4] = '{mode_maze, 2'd0, state_won};
        rounds[5] = '{mode_wire, 2'd3, state_lost};
        rounds[6] = '{mode_wire, 2'd1, state_won};
        rounds[7] = '{mode_wire, 2'd0, state_won};

        nrst     = 1'b0;
        buttons  = 6'd0;
        mode     = mode_wire;
        cut_mask = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;

        check_val("game_state", int'(game_state), int'(state_menu));
        check_val("strikes", int'(strikes), 0);
        check_val("wire_status", int'(wire_status), 0);
        check_val("wire_pos", int'(wire_pos), 0);

        for (int r = 0; r < 8; r++) begin
            press(btn_select);  // start a round
            wait_state(state_play);
            cut_mask = '0;
            check_val("strikes", int'(strikes), 0);
            check_val("wire_status", int'(wire_status), 0);
            check_val("wire_pos", int'(wire_pos), 0);
            check_layout();
            n = int'(layout.wire_num);
            right = model_right(layout);

            press(btn_left);  // wraps to the last wire
            wait_pos(n - 1);
            press(btn_right);
            wait_pos(0);

            if (rounds[r].mode != mode_wire) begin
                mode = rounds[r].mode;
                clear0 = clear_cnt;
                error0 = error_cnt;
                press(btn_select);
                check_val("wire_status", int'(wire_status), 0);
                press(btn_right);
                check_val("wire_pos", int'(wire_pos), 0);
                press(btn_left);
                check_val("wire_pos", int'(wire_pos), 0);
                check_val("game_state", int'(game_state), int'(state_play));
                check_pulses(clear0, error0, 0, 0);
                mode = mode_wire;
            end

            wrong_done = 0;
            for (int k = 0; k < int'(rounds[r].n_wrong); k++) begin
                pick_wrong(right, wrong, found);
                if (!found) break;  // small layouts run out of wrong wires
                cut_at(wrong, wrong_done + 1, 1'b0);
                wrong_done++;
                if (k == 0) begin
                    clear0 = clear_cnt;
                    error0 = error_cnt;
                    press(btn_select);  // cursor still on the cut wire
                    check_val("wire_status", int'(wire_status), int'(cut_mask));
                    check_val("strikes", int'(strikes), 1);
                    check_pulses(clear0, error0, 0, 0);
                end
            end

            if (wrong_done == strike_limit) begin
                exp_state = state_lost;
            end else begin
                cut_at(right, wrong_done, 1'b1);
                exp_state = state_won;
            end
            wait_state(exp_state);
            if (wrong_done == int'(rounds[r].n_wrong))
                check_val("game_state", int'(game_state), int'(rounds[r].exp_state));

            press(btn_back);
            wait_state(state_menu);
        end

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
source/wire_pkg.sv
source/button_sync.sv
source/wire_layout_gen.sv
source/wire_rule_solver.sv
source/wire_cut_detector.sv
source/wire_cursor.sv
source/game_fsm.sv
source/wire_game_top.sv
tests/wire_game_tb.sv

// File: run.sh
#!/bin/sh
# build and run the wire game testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f sim.f --top-module wire_game_tb -o wire_game_sim &&
./obj_dir/wire_game_sim > sim.log 2>&1
cat sim.log
grep -q "TESTS PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
